//--- sim.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --timing --assert -j 0 --top-module tb_dcache \
  -f sim.f --Mdir build -o tb_dcache \
  && ./build/tb_dcache > build/sim.log 2>&1 \
  || { echo "build or run error"; cat build/sim.log 2>/dev/null; exit 1; }
cat build/sim.log
grep -q "^ALL CHECKS PASSED$" build/sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

//--- testbench/tb_dcache.sv
//////////////////////////////////////////////////
// dcache testbench
// directed and random loads and stores, checked
// against a reference memory
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  // about 400 requests at worst-case miss latency with stalls
  localparam int          TIMEOUT = 20000;
  localparam logic [31:0] SEED    = 32'h5658_0c4d;

  logic      clk = 1'b0;
  logic      rst;
  logic      req_valid;
  cpu_req_t  req;
  logic      req_ready;
  logic      resp_valid;
  cpu_resp_t resp;
  logic      resp_ready;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_req_ready;
  logic      mem_w_valid;
  word_t     mem_wdata;
  logic      mem_w_ready;
  logic      mem_r_valid;
  word_t     mem_rdata;
  logic      mem_r_ready;

  logic [31:0] lfsr = SEED;
  word_t       ref_mem [addr_t];
  word_t       exp_q [$];
  logic        rd_q [$];
  addr_t       adr_q [$];
  word_t       exp_w;
  logic        was_rd;
  addr_t       was_adr;
  int          cyc = 0;
  int          acc_cnt = 0;
  int          rsp_cnt = 0;
  int          acc_cyc = 0;
  int          latency = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  logic        held = 1'b0;
  word_t       held_data = '0;
  logic        bp_mode = 1'b0;
  int          stretch = 0;

  always #5 clk = ~clk;

  dcache_top #(
    .SETS (64)
  ) uut (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .resp_ready_i    (resp_ready),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_req_ready_i (mem_req_ready),
    .mem_w_valid_o   (mem_w_valid),
    .mem_wdata_o     (mem_wdata),
    .mem_w_ready_i   (mem_w_ready),
    .mem_r_valid_i   (mem_r_valid),
    .mem_rdata_i     (mem_rdata),
    .mem_r_ready_o   (mem_r_ready)
  );

  tb_mem_model #(
    .SEED (SEED)
  ) u_mem (
    .clk             (clk),
    .rst             (rst),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_i       (mem_req),
    .mem_req_ready_o (mem_req_ready),
    .mem_w_valid_i   (mem_w_valid),
    .mem_wdata_i     (mem_wdata),
    .mem_w_ready_o   (mem_w_ready),
    .mem_r_valid_o   (mem_r_valid),
    .mem_rdata_o     (mem_rdata),
    .mem_r_ready_i   (mem_r_ready)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // unwritten words hold a pattern of their own address
  function automatic word_t expected_word(input addr_t a);
    addr_t wa;
    wa = {a[ADDR_W-1:3], 3'b000};
    if (ref_mem.exists(wa)) return ref_mem[wa];
    return {~wa, wa};
  endfunction

  function automatic void apply_write(input addr_t a, input word_t wd, input strb_t st);
    addr_t wa;
    word_t w;
    wa = {a[ADDR_W-1:3], 3'b000};
    w  = expected_word(wa);
    for (int b = 0; b < STRB_W; b++) begin
      if (st[b]) w[b*8 +: 8] = wd[b*8 +: 8];
    end
    ref_mem[wa] = w;
  endfunction

  task automatic check(input word_t got, input word_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic pace_ready();
    logic [31:0] r;
    if (!bp_mode) begin
      resp_ready = 1'b1;
    end else if (stretch == 0) begin
      r          = rand_bits(4);
      resp_ready = r[3];
      stretch    = int'(r[2:0]);  // hold this level a few cycles
    end else begin
      stretch--;
    end
  endtask

  // one blocking request, returns once its response is taken
  task automatic access(input addr_t a, input logic wr, input word_t wd, input strb_t st);
    int n;
    n         = acc_cnt;
    req.addr  = a;
    req.write = wr;
    req.wdata = wd;
    req.strb  = st;
    req_valid = 1'b1;
    while (acc_cnt == n) begin
      @(negedge clk);
      pace_ready();
    end
    req_valid = 1'b0;
    while (rsp_cnt != acc_cnt) begin
      @(negedge clk);
      pace_ready();
    end
  endtask

  // 8 sets, 4 tags, either word of the line
  task automatic random_access(input addr_t base);
    logic [31:0] r;
    addr_t       a;
    word_t       wd;
    r = rand_bits(6);
    a = base | (addr_t'(r[5:4]) << 10) | (addr_t'(r[3:1]) << 4) | (addr_t'(r[0]) << 3);
    wd[63:32] = rand_bits(32);
    wd[31:0]  = rand_bits(32);
    r = rand_bits(9);
    access(a, r[8], wd, r[7:0]);
  endtask

  task automatic report(input string name, input int errs_before);
    if (err_cnt == errs_before) $display("%s: pass", name);
    else $display("%s: fail, %0d errors", name, err_cnt - errs_before);
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // scoreboard, sampled at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (held) begin
        check(word_t'(resp_valid), word_t'(1), "response dropped before acceptance");
        check(resp.rdata, held_data, "response changed before acceptance");
      end
      if (resp_valid) begin
        check(word_t'(req_ready), word_t'(0), "req_ready high with response pending");
        if (!held) latency = cyc - acc_cyc;
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("response at %0t with no request outstanding", $time);
          err_cnt++;
        end else begin
          exp_w   = exp_q.pop_front();
          was_rd  = rd_q.pop_front();
          was_adr = adr_q.pop_front();
          if (was_rd) check(resp.rdata, exp_w, $sformatf("read data at %h", was_adr));
        end
        rsp_cnt++;
      end
      held      = resp_valid && !resp_ready;
      held_data = resp.rdata;
      if (req_valid && req_ready) begin
        acc_cnt++;
        acc_cyc = cyc;
        rd_q.push_back(!req.write);
        adr_q.push_back(req.addr);
        exp_q.push_back(expected_word(req.addr));
        if (req.write) apply_write(req.addr, req.wdata, req.strb);
      end
    end
  end

  initial begin
    int    e;
    int    wb;
    int    n;
    addr_t a;
    word_t wd;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    e = err_cnt;
    access(32'h0000_1000, 1'b0, '0, '0);
    check(word_t'(latency > 1), word_t'(1), "miss answered in one cycle");
    access(32'h0000_1008, 1'b0, '0, '0);  // other word, same line
    check(word_t'(latency), word_t'(1), "read hit latency");
    report("test 1 read miss then hit", e);

    e = err_cnt;
    access(32'h0000_2040, 1'b0, '0, '0);
    access(32'h0000_2040, 1'b1, 64'h1111_2222_3333_4444, 8'h0f);
    check(word_t'(latency), word_t'(1), "write hit latency");
    access(32'h0000_2048, 1'b1, 64'h5555_6666_7777_8888, 8'ha5);
    access(32'h0000_2040, 1'b1, 64'h9999_aaaa_bbbb_cccc, 8'h3c);
    access(32'h0000_2040, 1'b0, '0, '0);
    access(32'h0000_2048, 1'b0, '0, '0);
    report("test 2 partial write hits", e);

    e  = err_cnt;
    wb = u_mem.wb_lines;
    for (int k = 0; k < 3; k++) begin
      a  = 32'h0010_0050 | (addr_t'(k) << 10);  // set 5, three tags
      wd = {32'hd00d_0000 | addr_t'(k), ~a};
      access(a, 1'b1, wd, 8'hff);
    end
    for (int k = 0; k < 3; k++) begin
      a = 32'h0010_0050 | (addr_t'(k) << 10);
      access(a, 1'b0, '0, '0);
      access(a | 32'h8, 1'b0, '0, '0);
    end
    check(word_t'(u_mem.wb_lines > wb), word_t'(1), "no dirty line written back");
    for (int k = 0; k < 3; k++) begin
      for (int w = 0; w < 2; w++) begin
        a = 32'h0010_0050 | (addr_t'(k) << 10) | (addr_t'(w) << 3);
        if (u_mem.mem.exists(a)) check(u_mem.mem[a], expected_word(a), "write-back copy");
      end
    end
    report("test 3 dirty eviction", e);

    e = err_cnt;
    for (int i = 0; i < 300; i++) random_access(32'h0020_0000);
    report("test 4 random mix", e);

    e       = err_cnt;
    n       = acc_cnt;
    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) random_access(32'h0020_0000);
    bp_mode    = 1'b0;
    resp_ready = 1'b1;
    repeat (4) @(negedge clk);  // idle window, a stray response lands here
    check(word_t'(rsp_cnt - n), word_t'(40), "responses per request");
    check(word_t'(exp_q.size()), word_t'(0), "responses still outstanding");
    report("test 5 response back-pressure", e);

    $display("checks: %0d, errors: %0d, requests: %0d", check_cnt, err_cnt, acc_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/tb_mem_model.sv
//////////////////////////////////////////////////
// burst memory model for the dcache bus
// two-beat lines with random stall cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_model
  import dcache_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h5658_0c4d
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_req_valid_i,
  input  mem_req_t mem_req_i,
  output logic     mem_req_ready_o,
  input  logic     mem_w_valid_i,
  input  word_t    mem_wdata_i,
  output logic     mem_w_ready_o,
  output logic     mem_r_valid_o,
  output word_t    mem_rdata_o,
  input  logic     mem_r_ready_i
);

  typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mode_e;

  word_t       mem [addr_t];
  int          wb_lines = 0;
  logic [31:0] lfsr = SEED;
  mode_e       mode = M_IDLE;
  logic        beat_q = 1'b0;
  logic        sent_beat = 1'b0;
  line_addr_t  line_q = '0;
  logic        req_rdy = 1'b0;
  logic        w_rdy = 1'b0;
  logic        r_vld = 1'b0;
  word_t       r_data = '0;
  logic [31:0] r;
  logic        go;

  assign mem_req_ready_o = req_rdy;
  assign mem_w_ready_o   = w_rdy;
  assign mem_r_valid_o   = r_vld;
  assign mem_rdata_o     = r_data;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic word_t read_word(input addr_t a);
    if (mem.exists(a)) return mem[a];
    return {~a, a};  // untouched words carry their address
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      mode   = M_IDLE;
      beat_q = 1'b0;
    end else begin
      case (mode)
        M_IDLE: if (mem_req_valid_i && req_rdy) begin
          line_q = mem_req_i.line_addr;
          mode   = mem_req_i.write ? M_WRITE : M_READ;
          beat_q = 1'b0;
        end
        M_WRITE: if (mem_w_valid_i && w_rdy) begin
          mem[{line_q, beat_q, 3'b000}] = mem_wdata_i;
          if (beat_q) begin
            mode = M_IDLE;
            wb_lines++;
          end
          beat_q = ~beat_q;
        end
        M_READ: if (r_vld && mem_r_ready_i) begin
          if (beat_q) mode = M_IDLE;
          beat_q = ~beat_q;
        end
        default: mode = M_IDLE;
      endcase
    end
  end

  // outputs change on the falling edge, about one stall in four
  always @(negedge clk) begin
    r       = rand_bits(2);
    go      = (r[1:0] != 2'b00);
    req_rdy = !rst && (mode == M_IDLE) && go;
    w_rdy   = !rst && (mode == M_WRITE) && go;
    if (rst || mode != M_READ) begin
      r_vld = 1'b0;
    end else if (!r_vld || sent_beat != beat_q) begin
      r_vld     = go;  // a beat once offered stays until taken
      sent_beat = beat_q;
    end
    r_data = read_word({line_q, beat_q, 3'b000});
  end

endmodule

//--- logic/dcache_top.sv
//////////////////////////////////////////////////
// dcache top
// two-way write-back data cache, joins the FSM,
// tag store and line array
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
#(
  parameter int SETS = 64
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid_i,
  input  cpu_req_t  req_i,
  output logic      req_ready_o,
  output logic      resp_valid_o,
  output cpu_resp_t resp_o,
  input  logic      resp_ready_i,
  output logic      mem_req_valid_o,
  output mem_req_t  mem_req_o,
  input  logic      mem_req_ready_i,
  output logic      mem_w_valid_o,
  output word_t     mem_wdata_o,
  input  logic      mem_w_ready_i,
  input  logic      mem_r_valid_i,
  input  word_t     mem_rdata_i,
  output logic      mem_r_ready_o
);

  addr_t      lookup_addr;
  tag_upd_t   tag_upd;
  logic       hit;
  way_t       hit_way;
  way_t       victim_way;
  logic       victim_dirty;
  line_addr_t victim_addr;
  way_t       rd_way;
  addr_t      rd_addr;
  data_wr_t   data_wr;
  line_t      rd_line;

  dcache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_o          (resp_o),
    .resp_ready_i    (resp_ready_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_w_valid_o   (mem_w_valid_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_w_ready_i   (mem_w_ready_i),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .lookup_addr_o   (lookup_addr),
    .tag_upd_o       (tag_upd),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_i    (victim_way),
    .victim_dirty_i  (victim_dirty),
    .victim_addr_i   (victim_addr),
    .rd_way_o        (rd_way),
    .rd_addr_o       (rd_addr),
    .data_wr_o       (data_wr),
    .rd_line_i       (rd_line)
  );

  dcache_tag_store #(
    .SETS (SETS)
  ) u_tags (
    .clk            (clk),
    .rst            (rst),
    .lookup_addr_i  (lookup_addr),
    .tag_upd_i      (tag_upd),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_addr_o  (victim_addr)
  );

  dcache_data_array #(
    .SETS (SETS)
  ) u_data (
    .clk       (clk),
    .data_wr_i (data_wr),
    .rd_way_i  (rd_way),
    .rd_addr_i (rd_addr),
    .rd_line_o (rd_line)
  );

endmodule

//--- logic/dcache_ctrl.sv
//////////////////////////////////////////////////
// dcache controller
// blocking hit/miss FSM with write-back, two-beat
// fill and both valid/ready handshakes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // cpu side
  input  logic       req_valid_i,
  input  cpu_req_t   req_i,
  output logic       req_ready_o,
  output logic       resp_valid_o,
  output cpu_resp_t  resp_o,
  input  logic       resp_ready_i,
  // memory side
  output logic       mem_req_valid_o,
  output mem_req_t   mem_req_o,
  input  logic       mem_req_ready_i,
  output logic       mem_w_valid_o,
  output word_t      mem_wdata_o,
  input  logic       mem_w_ready_i,
  input  logic       mem_r_valid_i,
  input  word_t      mem_rdata_i,
  output logic       mem_r_ready_o,
  // tag store
  output addr_t      lookup_addr_o,
  output tag_upd_t   tag_upd_o,
  input  logic       hit_i,
  input  way_t       hit_way_i,
  input  way_t       victim_way_i,
  input  logic       victim_dirty_i,
  input  line_addr_t victim_addr_i,
  // data array
  output way_t       rd_way_o,
  output addr_t      rd_addr_o,
  output data_wr_t   data_wr_o,
  input  line_t      rd_line_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HIT,        // response held until accepted
    S_WB_ADDR,
    S_WB_DATA,
    S_FILL_ADDR,
    S_FILL_DATA
  } state_e;

  state_e    state_q, state_d;
  logic      ready_q;
  logic      beat_q;      // 0 = low word beat

  addr_t     addr_q;
  logic      write_q;
  word_t     wdata_q;
  strb_t     strb_q;
  way_t      way_q;
  mem_req_t  mem_req_q;
  cpu_resp_t resp_q;

  logic      accept;
  logic      w_hs;
  logic      r_hs;
  word_t     fill_word;

  assign accept = req_valid_i && ready_q;
  assign w_hs   = mem_w_valid_o && mem_w_ready_i;
  assign r_hs   = mem_r_valid_i && mem_r_ready_o;

  assign req_ready_o     = ready_q;
  assign resp_valid_o    = (state_q == S_HIT);
  assign resp_o          = resp_q;
  assign mem_req_valid_o = (state_q == S_WB_ADDR) || (state_q == S_FILL_ADDR);
  assign mem_req_o       = mem_req_q;
  assign mem_w_valid_o   = (state_q == S_WB_DATA);
  assign mem_wdata_o     = beat_q ? rd_line_i[LINE_W-1:WORD_W] : rd_line_i[WORD_W-1:0];
  assign mem_r_ready_o   = (state_q == S_FILL_DATA);

  // lookups come straight from the request while idle
  assign lookup_addr_o = (state_q == S_IDLE) ? req_i.addr : addr_q;
  assign rd_addr_o     = (state_q == S_IDLE) ? req_i.addr : addr_q;
  assign rd_way_o      = (state_q == S_IDLE) ? hit_way_i : way_q;

  // store word merged into its fill beat
  always_comb begin
    fill_word = mem_rdata_i;
    if (write_q && (addr_q[WORD_SEL_BIT] == beat_q)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb_q[b]) fill_word[b*8 +: 8] = wdata_q[b*8 +: 8];
      end
    end
  end

  always_comb begin
    data_wr_o = '0;
    tag_upd_o = '0;
    if (accept && hit_i && req_i.write) begin
      data_wr_o.en          = 1'b1;
      data_wr_o.way         = hit_way_i;
      data_wr_o.addr        = req_i.addr;
      data_wr_o.wdata       = req_i.wdata;
      data_wr_o.strb        = req_i.strb;
      tag_upd_o.mark_dirty  = 1'b1;
      tag_upd_o.way         = hit_way_i;
      tag_upd_o.addr        = req_i.addr;
    end else if (r_hs) begin
      data_wr_o.en    = 1'b1;
      data_wr_o.way   = way_q;
      data_wr_o.addr  = {addr_q[ADDR_W-1:OFFSET_W], beat_q, {WORD_SEL_BIT{1'b0}}};
      data_wr_o.wdata = fill_word;
      data_wr_o.strb  = '1;
      if (beat_q) begin  // last beat allocates
        tag_upd_o.alloc      = 1'b1;
        tag_upd_o.mark_dirty = write_q;
        tag_upd_o.way        = way_q;
        tag_upd_o.addr       = addr_q;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          if (hit_i) state_d = S_HIT;
          else if (victim_dirty_i) state_d = S_WB_ADDR;
          else state_d = S_FILL_ADDR;
        end
      end
      S_HIT:       if (resp_ready_i) state_d = S_IDLE;
      S_WB_ADDR:   if (mem_req_ready_i) state_d = S_WB_DATA;
      S_WB_DATA:   if (w_hs && beat_q) state_d = S_FILL_ADDR;
      S_FILL_ADDR: if (mem_req_ready_i) state_d = S_FILL_DATA;
      S_FILL_DATA: if (r_hs && beat_q) state_d = S_HIT;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      ready_q <= 1'b0;
      beat_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == S_IDLE);  // one cycle low after reset
      if (w_hs || r_hs) beat_q <= ~beat_q;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q              <= req_i.addr;
      write_q             <= req_i.write;
      wdata_q             <= req_i.wdata;
      strb_q              <= req_i.strb;
      way_q               <= hit_i ? hit_way_i : victim_way_i;
      resp_q.rdata        <= req_i.addr[WORD_SEL_BIT] ? rd_line_i[LINE_W-1:WORD_W]
                                                      : rd_line_i[WORD_W-1:0];
      mem_req_q.line_addr <= victim_dirty_i ? victim_addr_i
                                            : req_i.addr[ADDR_W-1:OFFSET_W];
      mem_req_q.write     <= victim_dirty_i;
    end
    if (w_hs && beat_q) begin  // write-back done, now fetch
      mem_req_q.line_addr <= addr_q[ADDR_W-1:OFFSET_W];
      mem_req_q.write     <= 1'b0;
    end
    if (r_hs && (beat_q == addr_q[WORD_SEL_BIT])) begin
      resp_q.rdata <= mem_rdata_i;
    end
  end

  a_resp_hold : assert property (@(posedge clk) disable iff (rst)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
    else $error("ctrl: response dropped or changed before acceptance");

  // write-back and fill each start on the low beat
  a_burst_start : assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_o && mem_req_ready_i |=> !beat_q)
    else $error("ctrl: burst started with the beat counter on the high word");

endmodule

//--- logic/dcache_data_array.sv
//////////////////////////////////////////////////
// dcache data array
// two ways of 128-bit lines, byte-strobed word
// writes and asynchronous line read
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_data_array
  import dcache_pkg::*;
#(
  parameter int SETS = 64
) (
  input  logic     clk,
  input  data_wr_t data_wr_i,
  input  way_t     rd_way_i,
  input  addr_t    rd_addr_i,
  output line_t    rd_line_o
);

  localparam int IDX_W = $clog2(SETS);

  line_t lines_q [WAYS][SETS];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             wr_half;

  assign wr_idx  = data_wr_i.addr[OFFSET_W +: IDX_W];
  assign wr_half = data_wr_i.addr[WORD_SEL_BIT];  // 1 = upper word
  assign rd_idx  = rd_addr_i[OFFSET_W +: IDX_W];

  always_ff @(posedge clk) begin
    if (data_wr_i.en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (data_wr_i.strb[b]) begin
          lines_q[data_wr_i.way][wr_idx][(wr_half ? WORD_W : 0) + b*8 +: 8]
            <= data_wr_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // async read, controller picks the word
  assign rd_line_o = lines_q[rd_way_i][rd_idx];

endmodule

//--- logic/dcache_tag_store.sv
//////////////////////////////////////////////////
// dcache tag store
// tag, valid and dirty per way and set, hit
// lookup and victim choice by a toggling counter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_tag_store
  import dcache_pkg::*;
#(
  parameter int SETS = 64
) (
  input  logic       clk,
  input  logic       rst,
  input  addr_t      lookup_addr_i,
  input  tag_upd_t   tag_upd_i,
  output logic       hit_o,
  output way_t       hit_way_o,
  output way_t       victim_way_o,
  output logic       victim_dirty_o,
  output line_addr_t victim_addr_o
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

  logic [TAG_W-1:0] tag_q [WAYS][SETS];
  logic [SETS-1:0]  valid_q [WAYS];
  logic [SETS-1:0]  dirty_q [WAYS];
  way_t             victim_q;

  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;
  logic [IDX_W-1:0] upd_idx;
  logic [WAYS-1:0]  hit_w;

  assign lk_idx  = lookup_addr_i[OFFSET_W +: IDX_W];
  assign lk_tag  = lookup_addr_i[ADDR_W-1 -: TAG_W];
  assign upd_idx = tag_upd_i.addr[OFFSET_W +: IDX_W];

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_w[w] = valid_q[w][lk_idx] && (tag_q[w][lk_idx] == lk_tag);
      if (hit_w[w]) hit_way_o = way_t'(w);
    end
  end

  assign hit_o          = |hit_w;
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = valid_q[victim_q][lk_idx] && dirty_q[victim_q][lk_idx];
  assign victim_addr_o  = {tag_q[victim_q][lk_idx], lk_idx};  // rebuilt line address

  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else begin
      victim_q <= way_t'(victim_q + 1'b1);  // free running
      if (tag_upd_i.alloc) begin
        valid_q[tag_upd_i.way][upd_idx] <= 1'b1;
        dirty_q[tag_upd_i.way][upd_idx] <= tag_upd_i.mark_dirty;  // write miss fills dirty
      end else if (tag_upd_i.mark_dirty) begin
        dirty_q[tag_upd_i.way][upd_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_upd_i.alloc) begin
      tag_q[tag_upd_i.way][upd_idx] <= tag_upd_i.addr[ADDR_W-1 -: TAG_W];
    end
  end

  // a line must never be resident in two ways
  a_single_hit : assert property (@(posedge clk) disable iff (rst) $onehot0(hit_w))
    else $error("tag store: address hits in more than one way");

endmodule

//--- logic/dcache_pkg.sv
//////////////////////////////////////////////////
// dcache shared definitions
// widths, address fields and the packed structs
// passed between controller, tags and data lines
//////////////////////////////////////////////////
package dcache_pkg;

  localparam int ADDR_W       = 32;
  localparam int WORD_W       = 64;
  localparam int STRB_W       = WORD_W / 8;
  localparam int LINE_W       = 128;
  localparam int OFFSET_W     = 4;   // 16 bytes per line
  localparam int WORD_SEL_BIT = 3;   // upper or lower word of a line
  localparam int WAYS         = 2;

  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [STRB_W-1:0]            strb_t;
  typedef logic [LINE_W-1:0]            line_t;
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [ADDR_W-OFFSET_W-1:0]   line_addr_t;  // address without offset
  typedef logic [$clog2(WAYS)-1:0]      way_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    strb_t strb;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;  // don't care on writes
  } cpu_resp_t;

  typedef struct packed {
    line_addr_t line_addr;
    logic       write;
  } mem_req_t;

  // alloc stores the tag and sets valid, mark_dirty sets dirty
  typedef struct packed {
    logic  alloc;
    logic  mark_dirty;
    way_t  way;
    addr_t addr;
  } tag_upd_t;

  typedef struct packed {
    logic  en;
    way_t  way;
    addr_t addr;   // word select bit places the word
    word_t wdata;
    strb_t strb;
  } data_wr_t;

endpackage
